//--- Makefile
TOP := rv_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

//--- rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic           clk,
  input  logic           reset,
  output rv_pkg::word_t  imem_addr,
  input  rv_pkg::instr_t imem_data,
  output rv_pkg::word_t  dmem_addr,
  input  rv_pkg::word_t  dmem_rdata,
  output rv_pkg::word_t  dmem_wdata,
  output logic           dmem_we,
  output logic           ebreak
);

  rv_pkg::fetch_t if_id;
  rv_pkg::ctrl_t  ctrl;
  rv_pkg::word_t  imm;
  rv_pkg::word_t  rs1_data;
  rv_pkg::word_t  rs2_data;
  logic           rd_we;
  rv_pkg::word_t  rd_data;
  logic           taken;
  rv_pkg::word_t  target;
  logic           halted;

  // ------------------------------
  // Stage one
  // ------------------------------
  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) fetch_stage (
    .clk      (clk),
    .reset    (reset),
    .taken    (taken),
    .target   (target),
    .halted   (halted),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .fetch    (if_id)
  );

  // ------------------------------
  // Stage two
  // ------------------------------
  rv_decode decode (
    .fetch(if_id),
    .ctrl (ctrl),
    .imm  (imm)
  );

  rv_regfile regfile (
    .clk     (clk),
    .reset   (reset),
    .rs1     (ctrl.rs1),
    .rs2     (ctrl.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rd_we   (rd_we),
    .rd      (ctrl.rd),
    .rd_data (rd_data)
  );

  rv_execute execute (
    .clk       (clk),
    .reset     (reset),
    .fetch     (if_id),
    .ctrl      (ctrl),
    .imm       (imm),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rd_we     (rd_we),
    .rd_data   (rd_data),
    .taken     (taken),
    .target    (target),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .halted    (halted)
  );

  assign ebreak = halted;

endmodule

`default_nettype wire

//--- rv_core_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_assertions (
  input logic          clk,
  input logic          reset,
  input rv_pkg::word_t imem_addr,
  input rv_pkg::word_t dmem_addr,
  input logic          dmem_we,
  input logic          ebreak
);

  // Halt is sticky until the next reset
  halt_sticky: assert property (@(posedge clk) disable iff (reset) ebreak |=> ebreak)
    else $error("ebreak fell without a reset");

  no_store_halted: assert property (@(posedge clk) disable iff (reset) ebreak |-> !dmem_we)
    else $error("store issued while halted");

  store_aligned: assert property (@(posedge clk) disable iff (reset)
                                  dmem_we |-> (dmem_addr[1:0] == 2'b00))
    else $error("store address not word aligned");

  // pc only ever moves in words
  fetch_aligned: assert property (@(posedge clk) disable iff (reset)
                                  imem_addr[1:0] == 2'b00)
    else $error("fetch address not word aligned");

endmodule

bind rv_core rv_core_assertions rv_core_assertions_inst (
  .clk      (clk),
  .reset    (reset),
  .imem_addr(imem_addr),
  .dmem_addr(dmem_addr),
  .dmem_we  (dmem_we),
  .ebreak   (ebreak)
);

`default_nettype wire

//--- rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

  localparam rv_pkg::word_t  RESET_PC     = 32'h0000_0000;
  localparam int             NUM_TESTS    = 8;
  localparam int             BODY_LEN     = 40;
  localparam int             HALT_TIMEOUT = 3000;
  localparam int             MODEL_LIMIT  = 1000;
  // pc of the AUIPC that loads x17
  localparam int             JUMP_BASE    = 64;
  localparam rv_pkg::instr_t EBREAK_INSN  = 32'h0010_0073;

  logic           clk;
  logic           reset;
  rv_pkg::word_t  imem_addr;
  rv_pkg::instr_t imem_data;
  rv_pkg::word_t  dmem_addr;
  rv_pkg::word_t  dmem_rdata;
  rv_pkg::word_t  dmem_wdata;
  logic           dmem_we;
  logic           ebreak;

  rv_pkg::instr_t imem [256];
  rv_pkg::word_t  dmem [256];
  rv_pkg::word_t  ref_mem [256];
  rv_pkg::word_t  ref_regs [32];
  rv_pkg::word_t  exp_addr [$];
  rv_pkg::word_t  exp_data [$];
  rv_pkg::word_t  got_addr [$];
  rv_pkg::word_t  got_data [$];
  logic [31:0]    lfsr;
  int             late_stores;
  int             test_errors;
  logic           timed_out;
  string          test_name;

  rv_core #(
    .RESET_PC(RESET_PC)
  ) rv_core_inst (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .dmem_addr (dmem_addr),
    .dmem_rdata(dmem_rdata),
    .dmem_wdata(dmem_wdata),
    .dmem_we   (dmem_we),
    .ebreak    (ebreak)
  );

  // Both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Store commit and capture
  always @(posedge clk) begin
    if (!reset && dmem_we) begin
      dmem[dmem_addr[9:2]] = dmem_wdata;
      got_addr.push_back(dmem_addr);
      got_data.push_back(dmem_wdata);
      if (ebreak) begin
        late_stores++;
      end
    end
  end

  // ------------------------------
  // Random bits and encoders
  // ------------------------------
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic rv_pkg::instr_t enc_r(logic [6:0] f7, rv_pkg::reg_addr_t rs2,
                                           rv_pkg::reg_addr_t rs1, logic [2:0] f3,
                                           rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
  endfunction

  function automatic rv_pkg::instr_t enc_i(logic [11:0] imm, rv_pkg::reg_addr_t rs1,
                                           logic [2:0] f3, rv_pkg::reg_addr_t rd,
                                           logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::instr_t enc_s(logic [11:0] imm, rv_pkg::reg_addr_t rs2,
                                           rv_pkg::reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic rv_pkg::instr_t enc_b(logic [12:0] imm, rv_pkg::reg_addr_t rs2,
                                           rv_pkg::reg_addr_t rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
  endfunction

  function automatic rv_pkg::instr_t enc_u(logic [19:0] imm, rv_pkg::reg_addr_t rd,
                                           logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv_pkg::instr_t enc_j(logic [20:0] imm, rv_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic rv_pkg::word_t alu_ref(logic [2:0] f3, logic alt, rv_pkg::word_t a,
                                            rv_pkg::word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic run_model();
    rv_pkg::word_t  pc;
    rv_pkg::word_t  next;
    rv_pkg::instr_t ins;
    rv_pkg::word_t  a;
    rv_pkg::word_t  b;
    rv_pkg::word_t  imm_i;
    rv_pkg::word_t  imm_s;
    rv_pkg::word_t  imm_b;
    rv_pkg::word_t  imm_j;
    rv_pkg::word_t  addr;
    rv_pkg::word_t  wval;
    logic           wr;
    logic           done;
    int             steps;
    pc    = RESET_PC;
    done  = 1'b0;
    steps = 0;
    exp_addr = {};
    exp_data = {};
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    while (!done && steps < MODEL_LIMIT) begin
      ins   = imem[pc[9:2]];
      a     = ref_regs[ins[19:15]];
      b     = ref_regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      wr    = 1'b1;
      wval  = '0;
      next  = pc + 32'd4;
      case (ins[6:0])
        rv_pkg::OP_LUI:   wval = {ins[31:12], 12'h000};
        rv_pkg::OP_AUIPC: wval = pc + {ins[31:12], 12'h000};
        rv_pkg::OP_JAL: begin
          wval = pc + 32'd4;
          next = pc + imm_j;
        end
        rv_pkg::OP_JALR: begin
          wval = pc + 32'd4;
          next = (a + imm_i) & ~32'd1;
        end
        rv_pkg::OP_BRANCH: begin
          wr = 1'b0;
          if (branch_ref(ins[14:12], a, b)) begin
            next = pc + imm_b;
          end
        end
        rv_pkg::OP_LOAD: begin
          addr = a + imm_i;
          wval = ref_mem[addr[9:2]];
        end
        rv_pkg::OP_STORE: begin
          wr   = 1'b0;
          addr = a + imm_s;
          ref_mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        rv_pkg::OP_IMM: wval = alu_ref(ins[14:12], (ins[14:12] == 3'd5) && ins[30], a, imm_i);
        rv_pkg::OP_REG: wval = alu_ref(ins[14:12], ins[30], a, b);
        rv_pkg::OP_SYSTEM: begin
          wr   = 1'b0;
          done = 1'b1;
        end
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
        ref_regs[ins[11:7]] = wval;
      end
      pc = next;
      steps++;
    end
    if (!done) begin
      $display("ERROR: %s: model never reached the ebreak", test_name);
      test_errors++;
    end
  endtask

  // ------------------------------
  // Program generator
  // ------------------------------
  task automatic gen_program(int t);
    int                k;
    int                skip;
    logic [31:0]       r;
    logic [2:0]        kind;
    logic [2:0]        f3;
    logic [11:0]       imm;
    logic              alt;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    for (int i = 0; i < 256; i++) begin
      imem[i]    = enc_i(12'(i), 5'd0, 3'd0, 5'd0, rv_pkg::OP_IMM);
      dmem[i]    = {16'hd00d, 8'(t), 8'(i)};
      ref_mem[i] = dmem[i];
    end
    k = 0;
    for (int i = 1; i < 16; i++) begin
      r = take_bits(12);
      imem[k] = enc_i(r[11:0], 5'd0, 3'd0, 5'(i), rv_pkg::OP_IMM);
      k++;
    end
    // Data base in x16 and jump base in x17
    imem[k] = enc_i(12'h200, 5'd0, 3'd0, 5'd16, rv_pkg::OP_IMM);
    k++;
    imem[k] = enc_u(20'h0, 5'd17, rv_pkg::OP_AUIPC);
    k++;
    for (int n = 0; n < BODY_LEN; n++) begin
      r    = take_bits(3);
      kind = r[2:0];
      r    = take_bits(12);
      rd   = (r[3:0] == 4'd0) ? 5'd1 : {1'b0, r[3:0]};
      rs1  = {1'b0, r[7:4]};
      rs2  = {1'b0, r[11:8]};
      case (kind)
        3'd0: begin
          r   = take_bits(4);
          f3  = r[2:0];
          alt = r[3] && (f3 == 3'd0 || f3 == 3'd5);
          imem[k] = enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
        end
        3'd1: begin
          r  = take_bits(16);
          f3 = r[15:13];
          if (f3 == 3'd1) begin
            imm = {7'b0, r[4:0]};
          end else if (f3 == 3'd5) begin
            imm = {1'b0, r[12], 5'b0, r[4:0]};
          end else begin
            imm = r[11:0];
          end
          imem[k] = enc_i(imm, rs1, f3, rd, rv_pkg::OP_IMM);
        end
        3'd2: begin
          r = take_bits(20);
          imem[k] = enc_u(r[19:0], rd, rv_pkg::OP_LUI);
        end
        3'd3: begin
          r = take_bits(20);
          imem[k] = enc_u(r[19:0], rd, rv_pkg::OP_AUIPC);
        end
        3'd4: begin
          r = take_bits(5);
          imem[k] = enc_s({5'b0, r[4:0], 2'b00}, rs2, 5'd16);
        end
        3'd5: begin
          r = take_bits(5);
          imem[k] = enc_i({5'b0, r[4:0], 2'b00}, 5'd16, 3'b010, rd, rv_pkg::OP_LOAD);
        end
        3'd6: begin
          // Forward branch over one or two slots with no funct3 of 2 or 3
          r    = take_bits(4);
          f3   = r[2:0];
          if (f3[2:1] == 2'b01) begin
            f3[1] = 1'b0;
          end
          skip = r[3] ? 2 : 1;
          imem[k] = enc_b(13'(4 * (skip + 1)), rs2, rs1, f3);
        end
        default: begin
          r    = take_bits(2);
          skip = r[0] ? 2 : 1;
          if (r[1]) begin
            imem[k] = enc_j(21'(4 * (skip + 1)), rd);
          end else begin
            imem[k] = enc_i(12'(4 * (k + 1 + skip) - JUMP_BASE), 5'd17, 3'd0, rd,
                            rv_pkg::OP_JALR);
          end
        end
      endcase
      k++;
    end
    // Register dump then halt
    for (int i = 1; i < 16; i++) begin
      imem[k] = enc_s(12'(256 + 4 * (i - 1)), 5'(i), 5'd16);
      k++;
    end
    imem[k] = EBREAK_INSN;
    // Store right behind the halt that must never commit
    imem[k + 1] = enc_s(12'h000, 5'd1, 5'd16);
  endtask

  // ------------------------------
  // Checks and test flow
  // ------------------------------
  task automatic check_word(string what, rv_pkg::word_t expected, rv_pkg::word_t actual);
    if (expected !== actual) begin
      $display("[FAIL] %s %s: expected %08h, actual %08h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_results();
    int n;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      if (ebreak !== 1'b1) begin
        $display("ERROR: %s: ebreak dropped while halted", test_name);
        test_errors++;
      end
    end
    if (late_stores != 0) begin
      $display("ERROR: %s: %0d stores happened after ebreak", test_name, late_stores);
      test_errors++;
    end
    if (got_addr.size() != exp_addr.size()) begin
      $display("[FAIL] %s store count: expected %0d, actual %0d", test_name,
               exp_addr.size(), got_addr.size());
      test_errors++;
    end
    n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      check_word($sformatf("store %0d addr", i), exp_addr[i], got_addr[i]);
      check_word($sformatf("store %0d data", i), exp_data[i], got_data[i]);
    end
    for (int i = 0; i < 256; i++) begin
      check_word($sformatf("dmem[%0d]", i), ref_mem[i], dmem[i]);
    end
  endtask

  task automatic run_test(int t);
    int cycles;
    test_name   = $sformatf("prog%0d", t);
    test_errors = 0;
    reset       = 1'b1;
    gen_program(t);
    run_model();
    got_addr    = {};
    got_data    = {};
    late_stores = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_word("reset imem_addr", RESET_PC, imem_addr);
    if (ebreak !== 1'b0 || dmem_we !== 1'b0) begin
      $display("ERROR: %s: ebreak or dmem_we not low during reset", test_name);
      test_errors++;
    end
    reset  = 1'b0;
    cycles = 0;
    while (ebreak !== 1'b1 && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (ebreak !== 1'b1) begin
      $display("ERROR: %s: timeout, ebreak did not rise in %0d cycles", test_name,
               HALT_TIMEOUT);
      test_errors++;
      timed_out = 1'b1;
    end else begin
      check_results();
    end
  endtask

  initial begin
    int passed;
    int failed;
    passed    = 0;
    failed    = 0;
    timed_out = 1'b0;
    reset     = 1'b1;
    lfsr      = 32'd97;
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_test(t);
      if (test_errors == 0) begin
        passed++;
        $display("PASS %s: %0d stores", test_name, got_addr.size());
      end else begin
        failed++;
        $display("FAIL %s: %0d errors", test_name, test_errors);
      end
    end
    $display("Tests: %0d passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
  input  rv_pkg::fetch_t fetch,
  output rv_pkg::ctrl_t  ctrl,
  output rv_pkg::word_t  imm
);

  localparam rv_pkg::instr_t EBREAK = 32'h0010_0073;

  rv_pkg::instr_t instr;
  logic [6:0]     opcode;
  logic [2:0]     funct3;
  logic           funct7_b5;
  rv_pkg::word_t  imm_i;
  rv_pkg::word_t  imm_s;
  rv_pkg::word_t  imm_b;
  rv_pkg::word_t  imm_u;
  rv_pkg::word_t  imm_j;

  // ALU op for OP and OP-IMM; alt picks SUB or SRA
  function automatic rv_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign instr     = fetch.instr;
  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  // ------------------------------
  // Immediate formats
  // ------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ------------------------------
  // Control decode
  // ------------------------------
  always_comb begin
    ctrl        = '0;
    ctrl.rd     = instr[11:7];
    ctrl.rs1    = instr[19:15];
    ctrl.rs2    = instr[24:20];
    ctrl.funct3 = funct3;
    ctrl.alu_op = rv_pkg::ALU_ADD;
    ctrl.wb_sel = rv_pkg::WB_ALU;
    imm         = '0;

    // Bubbles and unknown opcodes fall through as a NOP
    if (fetch.valid) begin
      case (opcode)
        rv_pkg::OP_LUI: begin
          ctrl.alu_op    = rv_pkg::ALU_PASS_B;
          ctrl.alu_b_imm = 1'b1;
          ctrl.reg_write = 1'b1;
          imm            = imm_u;
        end
        rv_pkg::OP_AUIPC: begin
          ctrl.alu_a_pc  = 1'b1;
          ctrl.alu_b_imm = 1'b1;
          ctrl.reg_write = 1'b1;
          imm            = imm_u;
        end
        rv_pkg::OP_JAL: begin
          ctrl.is_jal    = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.wb_sel    = rv_pkg::WB_PC_PLUS4;
          imm            = imm_j;
        end
        rv_pkg::OP_JALR: begin
          ctrl.is_jalr   = 1'b1;
          ctrl.alu_b_imm = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.wb_sel    = rv_pkg::WB_PC_PLUS4;
          imm            = imm_i;
        end
        rv_pkg::OP_BRANCH: begin
          ctrl.is_branch = 1'b1;
          imm            = imm_b;
        end
        rv_pkg::OP_LOAD: begin
          // LW only
          if (funct3 == 3'b010) begin
            ctrl.mem_read  = 1'b1;
            ctrl.alu_b_imm = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.wb_sel    = rv_pkg::WB_MEM;
            imm            = imm_i;
          end
        end
        rv_pkg::OP_STORE: begin
          if (funct3 == 3'b010) begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_b_imm = 1'b1;
            imm            = imm_s;
          end
        end
        rv_pkg::OP_IMM: begin
          ctrl.alu_op    = alu_op_of(funct3, (funct3 == 3'b101) && funct7_b5);
          ctrl.alu_b_imm = 1'b1;
          ctrl.reg_write = 1'b1;
          imm            = imm_i;
        end
        rv_pkg::OP_REG: begin
          ctrl.alu_op    = alu_op_of(funct3, funct7_b5);
          ctrl.reg_write = 1'b1;
        end
        rv_pkg::OP_SYSTEM: begin
          ctrl.is_ebreak = (instr == EBREAK);
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
  input  logic           clk,
  input  logic           reset,
  input  rv_pkg::fetch_t fetch,
  input  rv_pkg::ctrl_t  ctrl,
  input  rv_pkg::word_t  imm,
  input  rv_pkg::word_t  rs1_data,
  input  rv_pkg::word_t  rs2_data,
  output logic           rd_we,
  output rv_pkg::word_t  rd_data,
  output logic           taken,
  output rv_pkg::word_t  target,
  output rv_pkg::word_t  dmem_addr,
  output rv_pkg::word_t  dmem_wdata,
  input  rv_pkg::word_t  dmem_rdata,
  output logic           dmem_we,
  output logic           halted
);

  logic          active;
  rv_pkg::word_t alu_a;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t pc_plus4;
  logic [4:0]    shamt;
  logic          br_cond;

  // Nothing executes after the halt
  assign active = fetch.valid && !halted;

  // ------------------------------
  // ALU
  // ------------------------------
  assign alu_a = ctrl.alu_a_pc ? fetch.pc : rs1_data;
  assign alu_b = ctrl.alu_b_imm ? imm : rs2_data;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      rv_pkg::ALU_SUB:    alu_result = alu_a - alu_b;
      rv_pkg::ALU_AND:    alu_result = alu_a & alu_b;
      rv_pkg::ALU_OR:     alu_result = alu_a | alu_b;
      rv_pkg::ALU_XOR:    alu_result = alu_a ^ alu_b;
      rv_pkg::ALU_SLT:    alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
      rv_pkg::ALU_SLTU:   alu_result = {31'b0, alu_a < alu_b};
      rv_pkg::ALU_SLL:    alu_result = alu_a << shamt;
      rv_pkg::ALU_SRL:    alu_result = alu_a >> shamt;
      rv_pkg::ALU_SRA:    alu_result = rv_pkg::word_t'($signed(alu_a) >>> shamt);
      rv_pkg::ALU_PASS_B: alu_result = alu_b;
      default:            alu_result = alu_a + alu_b;
    endcase
  end

  // ------------------------------
  // Branches and jumps
  // ------------------------------
  always_comb begin
    case (ctrl.funct3)
      3'b000:  br_cond = (rs1_data == rs2_data);
      3'b001:  br_cond = (rs1_data != rs2_data);
      3'b100:  br_cond = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  br_cond = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  br_cond = (rs1_data < rs2_data);
      3'b111:  br_cond = (rs1_data >= rs2_data);
      default: br_cond = 1'b0;
    endcase
  end

  assign taken = active && (ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && br_cond));

  // JALR takes rs1 + imm from the ALU, low bit cleared
  assign target   = ctrl.is_jalr ? {alu_result[31:1], 1'b0} : fetch.pc + imm;
  assign pc_plus4 = fetch.pc + 32'd4;

  // Write-back
  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::WB_MEM:      rd_data = dmem_rdata;
      rv_pkg::WB_PC_PLUS4: rd_data = pc_plus4;
      default:             rd_data = alu_result;
    endcase
  end

  assign rd_we = active && ctrl.reg_write;

  // Data memory, address held at zero when not accessing
  assign dmem_addr  = (ctrl.mem_read || ctrl.mem_write) ? alu_result : '0;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = active && ctrl.mem_write;

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (active && ctrl.is_ebreak) begin
      halted <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            taken,
  input  rv_pkg::word_t   target,
  input  logic            halted,
  output rv_pkg::word_t   imem_addr,
  input  rv_pkg::instr_t  imem_data,
  output rv_pkg::fetch_t  fetch
);

  rv_pkg::word_t  pc;
  rv_pkg::word_t  pc_next;
  rv_pkg::word_t  if_pc;
  rv_pkg::instr_t if_instr;
  logic           if_valid;
  logic           flush;

  // Wrong-path fetch after a redirect, or anything after a halt
  assign flush = taken || halted;

  // Next pc, frozen once halted
  always_comb begin
    if (halted) begin
      pc_next = pc;
    end else if (taken) begin
      pc_next = target;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= RESET_PC;
      if_valid <= 1'b0;
    end else begin
      pc       <= pc_next;
      if_valid <= !flush;
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if_pc    <= pc;
    if_instr <= flush ? rv_pkg::NOP : imem_data;
  end

  assign imem_addr = pc;
  assign fetch     = '{pc: if_pc, instr: if_instr, valid: if_valid};

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

  // ------------------------------
  // Basic word types
  // ------------------------------
  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_addr_t;

  // ALU operation, decoded from opcode, funct3 and funct7
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  // Register write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC_PLUS4
  } wb_sel_e;

  // IF/ID register contents
  typedef struct packed {
    word_t  pc;
    instr_t instr;
    logic   valid;
  } fetch_t;

  typedef struct packed {
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    alu_op_e   alu_op;
    logic      alu_a_pc;
    logic      alu_b_imm;
    logic      reg_write;
    logic      mem_write;
    logic      mem_read;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      is_ebreak;
    logic [2:0] funct3;
    wb_sel_e   wb_sel;
  } ctrl_t;

  // ------------------------------
  // Opcodes
  // ------------------------------
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // addi x0, x0, 0
  localparam instr_t NOP = 32'h0000_0013;

endpackage

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              rd_we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data
);

  // x1..x31, x0 is not stored
  rv_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && (rd != 5'd0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Write happens at the end of the same stage, so no bypass needed
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- src.f
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
rv_core_assertions.sv
rv_core_tb.sv
